//--- Bender.yml
package:
  name: id_stage

export_include_dirs:
  - include

sources:
  - files:
      - rtl/id_pkg.sv
      - rtl/id_ifs.sv
      - rtl/inst_decoder.sv
      - rtl/gpr_file.sv
      - rtl/csr_file.sv
      - rtl/branch_unit.sv
      - rtl/id_stage.sv
  - target: test
    files:
      - bench/id_stage_props.sv
      - bench/tb_id_stage.sv

//--- bench/id_stage_props.sv
// bound assertions on the decode stage handshake, stall and redirect
`timescale 1ns/1ps
`default_nettype none
`include "id_defs.svh"

module id_stage_props import id_pkg::*; (
  input wire logic               i_clk,
  input wire logic               i_rst,
  input wire logic               i_es_allowin,
  input wire logic [`GPR_AW-1:0] i_es_rd,
  input wire logic [`GPR_AW-1:0] i_ms_rd,
  input wire logic [`GPR_AW-1:0] i_ws_rd,
  input wire logic [`CSR_AW-1:0] i_es_csr,
  input wire logic [`CSR_AW-1:0] i_ms_csr,
  input wire logic [`CSR_AW-1:0] i_ws_csr,
  input wire logic               o_es_valid,
  input wire logic               o_br_taken,
  input wire dec_ctrl_t          o_es_ctrl,
  input wire logic [`ILEN-1:0]   o_es_inst,
  input wire logic [`XLEN-1:0]   o_es_pc
);

  int unsigned fail_cnt = 0; // failed assertion count

  logic [`GPR_AW-1:0] src1;
  logic [`GPR_AW-1:0] src2;
  logic [`CSR_AW-1:0] csr_idx;
  logic               rd_hit;
  logic               csr_hit;

  assign src1    = o_es_inst[19:15];
  assign src2    = o_es_inst[24:20];
  assign csr_idx = o_es_inst[31:20];

  // a pending write to a used source blocks the bundle
  assign rd_hit  = (o_es_ctrl.rs1_used && src1 != '0 &&
                    (src1 == i_es_rd || src1 == i_ms_rd || src1 == i_ws_rd)) ||
                   (o_es_ctrl.rs2_used && src2 != '0 &&
                    (src2 == i_es_rd || src2 == i_ms_rd || src2 == i_ws_rd));
  assign csr_hit = (o_es_ctrl.csr_op != CSR_NONE) && csr_idx != '0 &&
                   (csr_idx == i_es_csr || csr_idx == i_ms_csr || csr_idx == i_ws_csr);

  a_stall_blocks: assert property (@(posedge i_clk) disable iff (i_rst)
    (rd_hit || csr_hit) |-> !o_es_valid)
    else begin
      $error("valid raised during hazard");
      fail_cnt++;
    end

  // redirect only from a control transfer that leaves this cycle
  a_redirect_fire: assert property (@(posedge i_clk) disable iff (i_rst)
    o_br_taken |-> (o_es_valid && i_es_allowin &&
                    (o_es_ctrl.is_branch || o_es_ctrl.is_jal || o_es_ctrl.is_jalr ||
                     o_es_ctrl.ecall || o_es_ctrl.mret)))
    else begin
      $error("redirect without fire");
      fail_cnt++;
    end

  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_es_valid && !i_es_allowin) |=> (o_es_valid && $stable(o_es_inst) && $stable(o_es_pc)))
    else begin
      $error("held item changed");
      fail_cnt++;
    end

endmodule

bind id_stage id_stage_props u_props (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_es_allowin (i_es_allowin),
  .i_es_rd      (i_es_rd),
  .i_ms_rd      (i_ms_rd),
  .i_ws_rd      (i_ws_rd),
  .i_es_csr     (i_es_csr),
  .i_ms_csr     (i_ms_csr),
  .i_ws_csr     (i_ws_csr),
  .o_es_valid   (o_es_valid),
  .o_br_taken   (o_br_taken),
  .o_es_ctrl    (o_es_ctrl),
  .o_es_inst    (o_es_inst),
  .o_es_pc      (o_es_pc)
);

`default_nettype wire

//--- bench/tb_id_stage.sv
// decode stage testbench with random stimulus, register model and checks
`timescale 1ns/1ps
`default_nettype none
`include "id_defs.svh"

module tb_id_stage import id_pkg::*; ();

  logic i_clk, i_rst, i_es_allowin, i_fs_valid;
  logic [31:0] i_fs_inst;
  logic [63:0] i_fs_pc, i_wb_gpr_wdata, i_wb_csr_wdata, o_es_pc, o_es_rs1data, o_es_rs2data;
  logic [63:0] o_es_csrdata, o_es_imm, o_br_target;
  logic i_wb_gpr_wen, i_wb_csr_wen, o_ds_allowin, o_es_valid, o_br_taken;
  logic [4:0] i_wb_gpr_waddr, i_es_rd, i_ms_rd, i_ws_rd, o_es_rd;
  logic [11:0] i_wb_csr_waddr, i_es_csr, i_ms_csr, i_ws_csr, o_es_csr;
  logic [31:0] o_es_inst;
  dec_ctrl_t o_es_ctrl;

  logic [63:0] regs_m [32]; // model of the gpr file
  logic [31:0] lfsr;
  int errs, fails, runs, asrt_base;

  id_stage id_stage_i (.*);

  always #50 i_clk = ~i_clk;

  // galois lfsr stepped once per bit
  function automatic logic [63:0] rnd(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
      errs++;
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout while waiting for %s", what);
    $display("tests failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    runs++;
    if (id_stage_i.u_props.fail_cnt != asrt_base) begin
      $display("assertion failures during test %s", name);
      asrt_base = id_stage_i.u_props.fail_cnt;
      errs++;
    end
    if (errs > 0) fails++;
    $display("test %0d %s: %s (%0d errors)", runs, name, (errs > 0) ? "FAIL" : "ok", errs);
    errs = 0;
  endtask

  task automatic wb_gpr(input logic [4:0] a, input logic [63:0] d);
    i_wb_gpr_wen = 1;
    i_wb_gpr_waddr = a;
    i_wb_gpr_wdata = d;
    @(posedge i_clk);
    #1;
    i_wb_gpr_wen = 0;
    if (a != 0) regs_m[a] = d;
  endtask

  task automatic issue(input logic [31:0] inst, input logic [63:0] pc);
    int n;
    n = 0;
    i_fs_inst = inst;
    i_fs_pc = pc;
    i_fs_valid = 1;
    while (!o_ds_allowin) begin
      @(posedge i_clk);
      #1;
      n++;
      if (n > 50) timed_out("fetch acceptance");
    end
    @(posedge i_clk);
    #1;
    i_fs_valid = 0;
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while (!o_es_valid) begin
      @(posedge i_clk);
      #1;
      n++;
      if (n > 50) timed_out("o_es_valid");
    end
  endtask

  task automatic fire(output logic taken, output logic [63:0] target);
    i_es_allowin = 1;
    #1;
    taken = o_br_taken;
    target = o_br_target;
    @(posedge i_clk);
    #1;
    i_es_allowin = 0;
  endtask

  function automatic alu_op_e expect_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? ALU_SUB : ALU_ADD;
      3'd1: return ALU_SLL;
      3'd2: return ALU_SLT;
      3'd3: return ALU_SLTU;
      3'd4: return ALU_XOR;
      3'd5: return alt ? ALU_SRA : ALU_SRL;
      3'd6: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  initial begin
    logic [31:0] inst;
    logic [63:0] pc, exp_imm, tgt, exp_tgt, a, b;
    logic [4:0] rs1, rs2, rd;
    logic [2:0] f3, sel;
    logic alt, tk, exp_tk;
    alu_op_e exp_alu;
    lfsr = 32'hacb439bc;
    errs = 0;
    fails = 0;
    runs = 0;
    asrt_base = 0;
    i_clk = 0;
    i_rst = 1;
    i_es_allowin = 0;
    i_fs_valid = 0;
    i_fs_inst = '0;
    i_fs_pc = '0;
    i_wb_gpr_wen = 0;
    i_wb_gpr_waddr = '0;
    i_wb_gpr_wdata = '0;
    i_wb_csr_wen = 0;
    i_wb_csr_waddr = '0;
    i_wb_csr_wdata = '0;
    i_es_rd = '0;
    i_ms_rd = '0;
    i_ws_rd = '0;
    i_es_csr = '0;
    i_ms_csr = '0;
    i_ws_csr = '0;
    for (int i = 0; i < 32; i++) regs_m[i] = '0;
    repeat (2) @(posedge i_clk);
    #1 i_rst = 0;
    check_value("reset valid/taken/allowin", {o_es_valid, o_br_taken, o_ds_allowin}, 3'b001);
    for (int r = 0; r < 32; r++) wb_gpr(r[4:0], rnd(64)); // x0 write must be dropped

    // alu-type decode and register reads
    for (int k = 0; k < 40; k++) begin
      rs1 = (k == 0) ? 5'd0 : 5'(rnd(5));
      rs2 = 5'(rnd(5));
      rd = 5'(rnd(5));
      f3 = 3'(rnd(3));
      sel = 3'(rnd(2));
      alt = rnd(1) && (f3 == 0 || f3 == 5);
      case (sel[1:0])
        2'd0: begin
          inst = {20'(rnd(20)), rd, 7'b0110111};
          exp_alu = ALU_PASS_B;
        end
        2'd1: begin
          inst = {20'(rnd(20)), rd, 7'b0010111};
          exp_alu = ALU_ADD;
        end
        2'd2: begin
          inst = {12'(rnd(12)), rs1, f3, rd, 7'b0010011};
          if (f3 == 1) inst[31:26] = 6'b0;
          if (f3 == 5) inst[31:26] = {1'b0, alt, 4'b0};
          exp_alu = expect_alu(f3, (f3 == 5) && alt);
        end
        default: begin
          inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
          exp_alu = expect_alu(f3, alt);
        end
      endcase
      if (sel[1] == 0) exp_imm = {{32{inst[31]}}, inst[31:12], 12'b0};
      else if (sel[1:0] == 2) exp_imm = {{52{inst[31]}}, inst[31:20]};
      else exp_imm = '0;
      pc = rnd(62) << 2;
      issue(inst, pc);
      check_value("valid one cycle after accept", o_es_valid, 1'b1);
      wait_valid();
      check_value("pc", o_es_pc, pc);
      check_value("rd", o_es_rd, rd);
      check_value("imm", o_es_imm, exp_imm);
      check_value("alu_op", o_es_ctrl.alu_op, exp_alu);
      check_value("gpr_wen/invalid", {o_es_ctrl.gpr_wen, o_es_ctrl.invalid}, 2'b10);
      check_value("rs1data", o_es_rs1data, regs_m[inst[19:15]]);
      check_value("rs2data", o_es_rs2data, regs_m[inst[24:20]]);
      fire(tk, tgt);
      if (tk) begin
        $display("error at %0t: redirect on alu instruction", $time);
        errs++;
      end
    end
    end_test("alu decode");

    // branches and jumps
    for (int k = 0; k < 48; k++) begin
      rs1 = 5'(rnd(5));
      rs2 = (k % 4 == 0) ? rs1 : 5'(rnd(5));
      rd = 5'(rnd(5));
      pc = rnd(62) << 2;
      exp_imm = rnd(12) << 1;
      exp_imm = {{51{exp_imm[12]}}, exp_imm[12:0]}; // b-type offset sign extended
      a = regs_m[rs1];
      b = regs_m[rs2];
      sel = 3'(rnd(3));
      if (sel == 6) begin
        exp_imm = {{43{exp_imm[20]}}, exp_imm[20:0]};
        inst = {exp_imm[20], exp_imm[10:1], exp_imm[11], exp_imm[19:12], rd, 7'b1101111};
        exp_tk = 1'b1;
        exp_tgt = pc + exp_imm;
      end else if (sel == 7) begin
        inst = {exp_imm[11:0], rs1, 3'b000, rd, 7'b1100111};
        exp_imm = {{52{exp_imm[11]}}, exp_imm[11:0]};
        exp_tk = 1'b1;
        exp_tgt = (a + exp_imm) & ~64'd1;
      end else begin
        f3 = (sel < 2) ? sel : sel + 3'd2;
        inst = {exp_imm[12], exp_imm[10:5], rs2, rs1, f3, exp_imm[4:1], exp_imm[11],
                7'b1100011};
        case (f3)
          3'd0: exp_tk = (a == b);
          3'd1: exp_tk = (a != b);
          3'd4: exp_tk = ($signed(a) < $signed(b));
          3'd5: exp_tk = ($signed(a) >= $signed(b));
          3'd6: exp_tk = (a < b);
          default: exp_tk = (a >= b);
        endcase
        exp_tgt = pc + exp_imm;
      end
      issue(inst, pc);
      wait_valid();
      check_value("taken before fire", o_br_taken, 1'b0);
      fire(tk, tgt);
      check_value("br_taken", tk, exp_tk);
      if (exp_tk) check_value("br_target", tgt, exp_tgt);
    end
    end_test("branch");

    // hazard stall on each later stage
    for (int k = 0; k < 9; k++) begin
      rs1 = 5'(rnd(5)) | 5'd1;
      rs2 = 5'(rnd(5));
      inst = {7'b0, rs2, rs1, 3'b000, 5'd3, 7'b0110011};
      if (k % 3 == 0) i_es_rd = rs1;
      else if (k % 3 == 1) i_ms_rd = rs1;
      else i_ws_rd = rs1;
      issue(inst, 64'h1000 + k * 4);
      repeat (3) begin
        check_value("valid under hazard", o_es_valid, 1'b0);
        @(posedge i_clk);
        #1;
      end
      i_es_rd = '0;
      i_ms_rd = '0;
      i_ws_rd = '0;
      wait_valid();
      check_value("held inst", o_es_inst, inst);
      check_value("held rs1data", o_es_rs1data, regs_m[rs1]);
      fire(tk, tgt);
    end
    end_test("hazard");

    // back-pressure on a jump
    inst = {20'h00100, 5'd1, 7'b1101111};
    issue(inst, 64'h2000);
    wait_valid();
    repeat (3) begin
      check_value("allowin held", o_ds_allowin, 1'b0);
      check_value("taken held", o_br_taken, 1'b0);
      check_value("inst held", o_es_inst, inst);
      check_value("pc held", o_es_pc, 64'h2000);
      @(posedge i_clk);
      #1;
    end
    fire(tk, tgt);
    check_value("taken after release", tk, 1'b1);
    end_test("backpressure");

    // trap entry, mepc readback and return
    a = rnd(62) << 2;
    pc = 64'h8000_0040;
    i_wb_csr_wen = 1;
    i_wb_csr_waddr = `CSR_MTVEC;
    i_wb_csr_wdata = a;
    @(posedge i_clk);
    #1;
    i_wb_csr_wen = 0;
    issue(32'h0000_0073, pc);
    wait_valid();
    fire(tk, tgt);
    check_value("ecall taken", tk, 1'b1);
    check_value("ecall target", tgt, a);
    issue({`CSR_MEPC, 5'd0, 3'b010, 5'd5, 7'b1110011}, pc + 4);
    wait_valid();
    check_value("csr index", o_es_csr, `CSR_MEPC);
    check_value("mepc read", o_es_csrdata, pc);
    fire(tk, tgt);
    issue(32'h3020_0073, pc + 8);
    wait_valid();
    fire(tk, tgt);
    check_value("mret taken", tk, 1'b1);
    check_value("mret target", tgt, pc);
    end_test("trap");

    // opcodes outside the subset
    for (int k = 0; k < 20; k++) begin
      inst = 32'(rnd(32));
      inst[1:0] = 2'b11;
      while (inst[6:2] inside {5'h0D, 5'h05, 5'h04, 5'h06, 5'h0C, 5'h0E, 5'h18, 5'h1B,
                               5'h19, 5'h00, 5'h08, 5'h1C}) inst[6:2] = 5'(rnd(5));
      issue(inst, 64'h3000);
      wait_valid();
      check_value("invalid/gpr_wen/mem_wen",
                  {o_es_ctrl.invalid, o_es_ctrl.gpr_wen, o_es_ctrl.mem_wen}, 3'b100);
      fire(tk, tgt);
    end
    end_test("illegal");

    $display("%0d tests run, %0d with errors", runs, fails);
    if (fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
rtl/id_pkg.sv
rtl/id_ifs.sv
rtl/inst_decoder.sv
rtl/gpr_file.sv
rtl/csr_file.sv
rtl/branch_unit.sv
rtl/id_stage.sv
bench/id_stage_props.sv
bench/tb_id_stage.sv

//--- include/id_defs.svh
// width and csr address macros for the decode stage
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

`define XLEN    64
`define ILEN    32
`define GPR_AW  5
`define CSR_AW  12

// machine mode csrs that exist
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

`define CAUSE_ECALL_M 64'd11 // environment call from m-mode

`endif

//--- rtl/branch_unit.sv
// branch_unit: branch condition, jump target and trap target select
`timescale 1ns/1ps
`default_nettype none
`include "id_defs.svh"

module branch_unit import id_pkg::*; (
  dec_ctrl_if.consumer     dec,
  input  logic [`XLEN-1:0] i_pc,
  input  logic [`XLEN-1:0] i_rs1data,
  input  logic [`XLEN-1:0] i_rs2data,
  input  logic [`XLEN-1:0] i_mtvec,
  input  logic [`XLEN-1:0] i_mepc,
  output logic             o_redirect,
  output logic [`XLEN-1:0] o_target
);

  logic             cond;
  logic [`XLEN-1:0] jalr_sum;

  always_comb begin
    case (dec.ctrl.br_func)
      BR_EQ:   cond = (i_rs1data == i_rs2data);
      BR_NE:   cond = (i_rs1data != i_rs2data);
      BR_LT:   cond = ($signed(i_rs1data) <  $signed(i_rs2data));
      BR_GE:   cond = ($signed(i_rs1data) >= $signed(i_rs2data));
      BR_LTU:  cond = (i_rs1data <  i_rs2data);
      BR_GEU:  cond = (i_rs1data >= i_rs2data);
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1data + dec.imm;

  assign o_redirect = (dec.ctrl.is_branch && cond) || dec.ctrl.is_jal || dec.ctrl.is_jalr ||
                      dec.ctrl.ecall || dec.ctrl.mret;

  always_comb begin
    if (dec.ctrl.ecall) begin
      o_target = i_mtvec;
    end else if (dec.ctrl.mret) begin
      o_target = i_mepc;
    end else if (dec.ctrl.is_jalr) begin
      o_target = {jalr_sum[`XLEN-1:1], 1'b0};
    end else begin
      o_target = i_pc + dec.imm; // branch and jal
    end
  end

endmodule

`default_nettype wire

//--- rtl/csr_file.sv
// csr_file: mstatus, mtvec, mepc, mcause with read port, write-back and trap update
`timescale 1ns/1ps
`default_nettype none
`include "id_defs.svh"

module csr_file (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic [`CSR_AW-1:0] i_raddr,
  output logic [`XLEN-1:0]   o_rdata,
  rf_wb_if.sink              wb,
  input  logic               i_ecall,
  input  logic               i_mret,
  input  logic [`XLEN-1:0]   i_epc,
  output logic [`XLEN-1:0]   o_mtvec,
  output logic [`XLEN-1:0]   o_mepc
);

  logic [`XLEN-1:0] mstatus;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;
  logic [`XLEN-1:0] mcause;
  logic             trap_save;

  assign trap_save = i_ecall && !i_mret; // mret only reads mepc

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (wb.csr_wen) begin
        case (wb.csr_waddr)
          `CSR_MSTATUS: mstatus <= wb.csr_wdata;
          `CSR_MTVEC:   mtvec   <= wb.csr_wdata;
          `CSR_MEPC:    mepc    <= wb.csr_wdata;
          `CSR_MCAUSE:  mcause  <= wb.csr_wdata;
          default: ;
        endcase
      end
      // trap entry wins over a write-back on the same edge
      if (trap_save) begin
        mepc   <= i_epc;
        mcause <= `CAUSE_ECALL_M;
      end
    end
  end

  always_comb begin
    case (i_raddr)
      `CSR_MSTATUS: o_rdata = mstatus;
      `CSR_MTVEC:   o_rdata = mtvec;
      `CSR_MEPC:    o_rdata = mepc;
      `CSR_MCAUSE:  o_rdata = mcause;
      default:      o_rdata = '0;
    endcase
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

endmodule

`default_nettype wire

//--- rtl/gpr_file.sv
// gpr_file: 32 x 64-bit general purpose registers, 2 read ports, 1 write port
`timescale 1ns/1ps
`default_nettype none
`include "id_defs.svh"

module gpr_file (
  input  logic               i_clk,
  input  logic [`GPR_AW-1:0] i_raddr1,
  input  logic [`GPR_AW-1:0] i_raddr2,
  output logic [`XLEN-1:0]   o_rdata1,
  output logic [`XLEN-1:0]   o_rdata2,
  rf_wb_if.sink              wb
);

  logic [`XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (wb.gpr_wen && wb.gpr_waddr != '0) begin
      regs[wb.gpr_waddr] <= wb.gpr_wdata;
    end
  end

  // x0 is hardwired
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

//--- rtl/id_ifs.sv
// interfaces dec_ctrl_if and rf_wb_if with modports
`timescale 1ns/1ps
`default_nettype none
`include "id_defs.svh"

// decoded instruction fields and controls
interface dec_ctrl_if import id_pkg::*; ();
  logic [`GPR_AW-1:0] rs1;
  logic [`GPR_AW-1:0] rs2;
  logic [`GPR_AW-1:0] rd;
  logic [`CSR_AW-1:0] csr_addr;
  logic [`XLEN-1:0]   imm;
  dec_ctrl_t          ctrl;

  modport producer (
    output rs1, rs2, rd, csr_addr, imm, ctrl
  );

  modport consumer (
    input rs1, rs2, rd, csr_addr, imm, ctrl
  );
endinterface

// write-back into the gpr and csr files
interface rf_wb_if ();
  logic               gpr_wen;
  logic [`GPR_AW-1:0] gpr_waddr;
  logic [`XLEN-1:0]   gpr_wdata;
  logic               csr_wen;
  logic [`CSR_AW-1:0] csr_waddr;
  logic [`XLEN-1:0]   csr_wdata;

  modport sink (
    input gpr_wen, gpr_waddr, gpr_wdata, csr_wen, csr_waddr, csr_wdata
  );
endinterface

`default_nettype wire

//--- rtl/id_pkg.sv
// decode package: opcode, alu op, branch and csr op enums, decode control struct
`default_nettype none

package id_pkg;

  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP_IMM_W = 7'b0011011,
    OPC_OP       = 7'b0110011,
    OPC_OP_W     = 7'b0111011,
    OPC_BRANCH   = 7'b1100011,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND,
    ALU_PASS_B,
    ALU_CSR     // gpr gets the old csr value
  } alu_op_e;

  // same codes as funct3 of the branch
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_func_e;

  typedef enum logic [1:0] {
    CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR
  } csr_op_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       src1_pc;   // operand 1 is pc
    logic       src2_imm;  // operand 2 is imm
    logic       word_cut;  // w form, 32-bit result sign extended
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;    // funct3 of load/store
    csr_op_e    csr_op;
    logic       rs1_used;
    logic       rs2_used;
    logic       is_branch;
    br_func_e   br_func;
    logic       is_jal;
    logic       is_jalr;
    logic       ecall;
    logic       mret;
    logic       invalid;
  } dec_ctrl_t;

endpackage

`default_nettype wire

//--- rtl/id_stage.sv
// id_stage: decode stage top with stage register, hazard stall, handshake and redirect
`timescale 1ns/1ps
`default_nettype none
`include "id_defs.svh"

module id_stage import id_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_es_allowin,
  input  logic               i_fs_valid,
  input  logic [`ILEN-1:0]   i_fs_inst,
  input  logic [`XLEN-1:0]   i_fs_pc,
  input  logic               i_wb_gpr_wen,
  input  logic [`GPR_AW-1:0] i_wb_gpr_waddr,
  input  logic [`XLEN-1:0]   i_wb_gpr_wdata,
  input  logic               i_wb_csr_wen,
  input  logic [`CSR_AW-1:0] i_wb_csr_waddr,
  input  logic [`XLEN-1:0]   i_wb_csr_wdata,
  input  logic [`GPR_AW-1:0] i_es_rd,
  input  logic [`GPR_AW-1:0] i_ms_rd,
  input  logic [`GPR_AW-1:0] i_ws_rd,
  input  logic [`CSR_AW-1:0] i_es_csr,
  input  logic [`CSR_AW-1:0] i_ms_csr,
  input  logic [`CSR_AW-1:0] i_ws_csr,
  output logic               o_ds_allowin,
  output logic               o_es_valid,
  output logic [`XLEN-1:0]   o_es_pc,
  output logic [`ILEN-1:0]   o_es_inst,
  output logic [`XLEN-1:0]   o_es_rs1data,
  output logic [`XLEN-1:0]   o_es_rs2data,
  output logic [`XLEN-1:0]   o_es_csrdata,
  output logic [`XLEN-1:0]   o_es_imm,
  output logic [`GPR_AW-1:0] o_es_rd,
  output logic [`CSR_AW-1:0] o_es_csr,
  output dec_ctrl_t          o_es_ctrl,
  output logic               o_br_taken,
  output logic [`XLEN-1:0]   o_br_target
);

  logic               ds_valid;
  logic               ds_ready_go;
  logic               ds_fire;
  logic [`ILEN-1:0]   ds_inst;
  logic [`XLEN-1:0]   ds_pc;
  logic [`XLEN-1:0]   rs1data;
  logic [`XLEN-1:0]   rs2data;
  logic [`XLEN-1:0]   mtvec;
  logic [`XLEN-1:0]   mepc;
  logic               redirect;
  logic [`GPR_AW-1:0] pend_rd  [3];
  logic [`CSR_AW-1:0] pend_csr [3];

  dec_ctrl_if dec_bus ();
  rf_wb_if    wb_bus ();

  assign wb_bus.gpr_wen   = i_wb_gpr_wen;
  assign wb_bus.gpr_waddr = i_wb_gpr_waddr;
  assign wb_bus.gpr_wdata = i_wb_gpr_wdata;
  assign wb_bus.csr_wen   = i_wb_csr_wen;
  assign wb_bus.csr_waddr = i_wb_csr_waddr;
  assign wb_bus.csr_wdata = i_wb_csr_wdata;

  // handshake
  assign o_ds_allowin = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_es_valid   = ds_valid && ds_ready_go;
  assign ds_fire      = o_es_valid && i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      ds_inst <= i_fs_inst;
      ds_pc   <= i_fs_pc;
    end
  end

  // writes still owed by es/ms/ws
  assign pend_rd  = '{i_es_rd, i_ms_rd, i_ws_rd};
  assign pend_csr = '{i_es_csr, i_ms_csr, i_ws_csr};

  always_comb begin
    ds_ready_go = 1'b1;
    for (int i = 0; i < 3; i++) begin
      if (pend_rd[i] != '0 &&
          ((dec_bus.ctrl.rs1_used && pend_rd[i] == dec_bus.rs1) ||
           (dec_bus.ctrl.rs2_used && pend_rd[i] == dec_bus.rs2))) begin
        ds_ready_go = 1'b0;
      end
      if (pend_csr[i] != '0 && dec_bus.ctrl.csr_op != CSR_NONE &&
          pend_csr[i] == dec_bus.csr_addr) begin
        ds_ready_go = 1'b0;
      end
    end
  end

  inst_decoder u_dec (
    .i_inst (ds_inst),
    .dec    (dec_bus)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (dec_bus.rs1),
    .i_raddr2 (dec_bus.rs2),
    .o_rdata1 (rs1data),
    .o_rdata2 (rs2data),
    .wb       (wb_bus)
  );

  csr_file u_csr (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_raddr (dec_bus.csr_addr),
    .o_rdata (o_es_csrdata),
    .wb      (wb_bus),
    .i_ecall (ds_fire && dec_bus.ctrl.ecall), // trap state moves on the fire edge
    .i_mret  (ds_fire && dec_bus.ctrl.mret),
    .i_epc   (ds_pc),
    .o_mtvec (mtvec),
    .o_mepc  (mepc)
  );

  branch_unit u_bru (
    .dec        (dec_bus),
    .i_pc       (ds_pc),
    .i_rs1data  (rs1data),
    .i_rs2data  (rs2data),
    .i_mtvec    (mtvec),
    .i_mepc     (mepc),
    .o_redirect (redirect),
    .o_target   (o_br_target)
  );

  assign o_br_taken = ds_fire && redirect;

  assign o_es_pc      = ds_pc;
  assign o_es_inst    = ds_inst;
  assign o_es_rs1data = rs1data;
  assign o_es_rs2data = rs2data;
  assign o_es_imm     = dec_bus.imm;
  assign o_es_ctrl    = dec_bus.ctrl;
  // zero index when nothing is written, so later stages raise no false hazard
  assign o_es_rd      = dec_bus.ctrl.gpr_wen ? dec_bus.rd : '0;
  assign o_es_csr     = (dec_bus.ctrl.csr_op != CSR_NONE) ? dec_bus.csr_addr : '0;

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
// inst_decoder: rv64 subset decode into register indices, immediate and controls
`timescale 1ns/1ps
`default_nettype none
`include "id_defs.svh"

module inst_decoder import id_pkg::*; (
  input  logic [`ILEN-1:0] i_inst,
  dec_ctrl_if.producer     dec
);

  localparam logic [`ILEN-1:0] INST_ECALL = 32'h0000_0073;
  localparam logic [`ILEN-1:0] INST_MRET  = 32'h3020_0073;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic             f7_zero;
  logic             f7_alt;
  logic             sh6_ok;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm;
  dec_ctrl_t        ctrl;

  // funct3 to alu op, alt is inst[30]
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                      input logic imm_form);
    case (f3)
      3'b000:  return (alt && !imm_form) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode  = i_inst[6:0];
  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);
  assign sh6_ok  = (i_inst[31:26] == 6'b000000) || (i_inst[31:26] == 6'b010000);

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    imm         = '0;
    case (opcode)
      OPC_LUI: begin
        ctrl.alu_op   = ALU_PASS_B;
        ctrl.src2_imm = 1'b1;
        ctrl.gpr_wen  = 1'b1;
        imm           = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.src1_pc  = 1'b1;
        ctrl.src2_imm = 1'b1;
        ctrl.gpr_wen  = 1'b1;
        imm           = imm_u;
      end
      OPC_OP_IMM, OPC_OP_IMM_W: begin
        ctrl.alu_op   = alu_sel(funct3, i_inst[30], 1'b1);
        ctrl.rs1_used = 1'b1;
        ctrl.src2_imm = 1'b1;
        ctrl.gpr_wen  = 1'b1;
        imm           = imm_i;
        if (opcode == OPC_OP_IMM_W) begin
          ctrl.word_cut = 1'b1;
          ctrl.invalid  = !((funct3 == 3'b000) || (funct3 == 3'b001 && f7_zero) ||
                            (funct3 == 3'b101 && (f7_zero || f7_alt)));
        end else if (funct3 == 3'b001) begin
          ctrl.invalid = (i_inst[31:26] != 6'b000000);
        end else if (funct3 == 3'b101) begin
          ctrl.invalid = !sh6_ok;
        end
      end
      OPC_OP, OPC_OP_W: begin
        ctrl.alu_op   = alu_sel(funct3, i_inst[30], 1'b0);
        ctrl.rs1_used = 1'b1;
        ctrl.rs2_used = 1'b1;
        ctrl.gpr_wen  = 1'b1;
        if (opcode == OPC_OP_W) begin
          ctrl.word_cut = 1'b1;
          ctrl.invalid  = !(((funct3 == 3'b000 || funct3 == 3'b101) && (f7_zero || f7_alt)) ||
                            (funct3 == 3'b001 && f7_zero));
        end else begin
          ctrl.invalid = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
        end
      end
      OPC_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.br_func   = br_func_e'(funct3);
        ctrl.rs1_used  = 1'b1;
        ctrl.rs2_used  = 1'b1;
        imm            = imm_b;
        ctrl.invalid   = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      OPC_JAL: begin
        ctrl.is_jal  = 1'b1;
        ctrl.src1_pc = 1'b1; // link is pc+4, formed in execute
        ctrl.gpr_wen = 1'b1;
        imm          = imm_j;
      end
      OPC_JALR: begin
        ctrl.is_jalr  = 1'b1;
        ctrl.src1_pc  = 1'b1;
        ctrl.rs1_used = 1'b1;
        ctrl.gpr_wen  = 1'b1;
        imm           = imm_i;
        ctrl.invalid  = (funct3 != 3'b000);
      end
      OPC_LOAD: begin
        ctrl.mem_ren  = 1'b1;
        ctrl.mem_op   = funct3;
        ctrl.rs1_used = 1'b1;
        ctrl.src2_imm = 1'b1;
        ctrl.gpr_wen  = 1'b1;
        imm           = imm_i;
        ctrl.invalid  = (funct3 == 3'b111);
      end
      OPC_STORE: begin
        ctrl.mem_wen  = 1'b1;
        ctrl.mem_op   = funct3;
        ctrl.rs1_used = 1'b1;
        ctrl.rs2_used = 1'b1;
        ctrl.src2_imm = 1'b1;
        imm           = imm_s;
        ctrl.invalid  = funct3[2];
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b001 || funct3 == 3'b010 || funct3 == 3'b011) begin
          ctrl.csr_op   = csr_op_e'(funct3[1:0]); // rw/rs/rc
          ctrl.alu_op   = ALU_CSR;
          ctrl.rs1_used = 1'b1;
          ctrl.gpr_wen  = 1'b1;
        end else if (i_inst == INST_ECALL) begin
          ctrl.ecall = 1'b1;
        end else if (i_inst == INST_MRET) begin
          ctrl.mret = 1'b1;
        end else begin
          ctrl.invalid = 1'b1;
        end
      end
      default: ctrl.invalid = 1'b1;
    endcase

    // nothing but the flag survives an illegal encoding
    if (ctrl.invalid) begin
      ctrl         = '0;
      ctrl.invalid = 1'b1;
    end
  end

  assign dec.rs1      = i_inst[19:15];
  assign dec.rs2      = i_inst[24:20];
  assign dec.rd       = i_inst[11:7];
  assign dec.csr_addr = i_inst[31:20];
  assign dec.imm      = imm;
  assign dec.ctrl     = ctrl;

endmodule

`default_nettype wire
